/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_icache
FILELIST  = sim.f
RUNFLAGS  = +verilator+error+limit+1000
BIN       = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* logic/icache.sv */
// read-only instruction cache with next-line prefetch
// cpu word port on one side, line memory port on the other
`timescale 1ns/1ps

module icache (
    input  logic              clk,
    input  logic              rst_n,
    // cpu side
    input  logic              mem_read,
    input  icache_pkg::word_t mem_address,
    output logic              mem_resp,
    output icache_pkg::word_t mem_rdata,
    // line memory side
    output logic              pmem_read,
    output icache_pkg::word_t pmem_address,
    input  icache_pkg::line_t pmem_rdata,
    input  logic              pmem_resp
);
    import icache_pkg::*;

    // control to datapath
    ctrl_t ctrl;
    // datapath to control
    stat_t stat;

    icache_control control (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_resp  (mem_resp),
        .pmem_read (pmem_read),
        .pmem_resp (pmem_resp),
        .stat      (stat),
        .ctrl      (ctrl)
    );

    icache_datapath datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .stat         (stat),
        .mem_address  (mem_address),
        .mem_rdata    (mem_rdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_address (pmem_address)
    );

endmodule

/* logic/icache_control.sv */
// instruction cache control
// FSM that sequences lookup, demand fill, buffer promotion and
// the single next-line prefetch after a demand miss
`timescale 1ns/1ps

module icache_control (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_read,
    output logic              mem_resp,
    output logic              pmem_read,
    input  logic              pmem_resp,
    input  icache_pkg::stat_t stat,
    output icache_pkg::ctrl_t ctrl
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_fill,
        st_promote,
        st_respond,
        st_prefetch
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        ctrl      = '0;
        mem_resp  = 1'b0;
        pmem_read = 1'b0;

        case (state_q)
            // wait for a cpu request
            st_idle: begin
                if (mem_read) begin
                    state_d = st_lookup;
                end
            end

            // arrays first, then the prefetch buffer
            st_lookup: begin
                if (stat.array_hit) begin
                    // one cycle hit
                    mem_resp      = 1'b1;
                    ctrl.load_lru = 1'b1;
                    state_d       = st_idle;
                end else if (stat.pbuf_valid && stat.pbuf_hit) begin
                    state_d = st_promote;
                end else begin
                    state_d = st_fill;
                end
            end

            // demand line fill, held until memory answers
            st_fill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctrl.load_way = 1'b1;
                    ctrl.fill_src = fill_mem;
                    state_d       = st_respond;
                end
            end

            // buffer line moves into the LRU way
            // word is taken from the buffer in the same cycle
            st_promote: begin
                ctrl.load_way   = 1'b1;
                ctrl.fill_src   = fill_pbuf;
                ctrl.load_lru   = 1'b1;
                ctrl.clear_pbuf = 1'b1;
                mem_resp        = 1'b1;
                state_d         = st_idle;
            end

            // line is in the arrays now
            st_respond: begin
                mem_resp       = 1'b1;
                ctrl.load_lru  = 1'b1;
                // address still held by the cpu this cycle
                ctrl.save_addr = 1'b1;
                if (stat.next_present) begin
                    state_d = st_idle;
                end else begin
                    state_d = st_prefetch;
                end
            end

            // next line into the buffer, new requests wait in idle
            st_prefetch: begin
                pmem_read     = 1'b1;
                ctrl.use_next = 1'b1;
                if (pmem_resp) begin
                    ctrl.load_pbuf = 1'b1;
                    state_d        = st_idle;
                end
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

endmodule

/* logic/icache_datapath.sv */
// instruction cache datapath
// two ways of tag, valid and line storage, one LRU bit per set and a
// one-line prefetch buffer; does hit detection, word select and forms
// the demand or next-line memory address
`timescale 1ns/1ps

module icache_datapath (
    input  logic              clk,
    input  logic              rst_n,
    input  icache_pkg::ctrl_t ctrl,
    output icache_pkg::stat_t stat,
    input  icache_pkg::word_t mem_address,
    output icache_pkg::word_t mem_rdata,
    input  icache_pkg::line_t pmem_rdata,
    output icache_pkg::word_t pmem_address
);
    import icache_pkg::*;

    // way storage
    tag_t                tag_q   [2][num_sets];
    line_t               data_q  [2][num_sets];
    logic [num_sets-1:0] valid_q [2];
    // per set, the way to replace next
    logic [num_sets-1:0] lru_q;

    // prefetch buffer
    line_t  pbuf_line_q;
    tag_t   pbuf_tag_q;
    index_t pbuf_index_q;
    logic   pbuf_valid_q;

    // next-line address saved for the prefetch request
    addr_t next_q;

    addr_t                           req;
    addr_t                           next_addr;
    logic [tag_bits+index_bits-1:0]  next_line_num;
    logic                            hit0;
    logic                            hit1;
    logic                            array_hit;
    logic                            pbuf_match;
    logic                            next_in_ways;
    logic                            next_in_pbuf;
    logic                            victim;
    logic                            used_way;
    line_t                           hit_line;
    line_t                           fill_line;
    line_t                           src_line;
    logic [offset_bits-3:0]          word_sel;

    assign req = addr_t'(mem_address);

    // tag compare against both ways
    assign hit0 = valid_q[0][req.index] && (tag_q[0][req.index] == req.tag);
    assign hit1 = valid_q[1][req.index] && (tag_q[1][req.index] == req.tag);
    assign array_hit = hit0 || hit1;

    // raw match on the buffer, control qualifies it with pbuf_valid
    assign pbuf_match = (pbuf_tag_q == req.tag) && (pbuf_index_q == req.index);

    // line following the request, wraps into the next tag
    assign next_line_num = {req.tag, req.index} + 1'b1;
    assign next_addr = {next_line_num, offset_t'(0)};

    assign next_in_ways =
        (valid_q[0][next_addr.index] && (tag_q[0][next_addr.index] == next_addr.tag)) ||
        (valid_q[1][next_addr.index] && (tag_q[1][next_addr.index] == next_addr.tag));
    assign next_in_pbuf = pbuf_valid_q &&
        (pbuf_tag_q == next_addr.tag) && (pbuf_index_q == next_addr.index);

    always_comb begin
        stat.array_hit    = array_hit;
        stat.pbuf_hit     = pbuf_match;
        stat.pbuf_valid   = pbuf_valid_q;
        stat.next_present = next_in_ways || next_in_pbuf;
    end

    // fills always go to the LRU way
    assign victim = lru_q[req.index];
    // way touched by this access, hit way if there is one
    assign used_way = array_hit ? hit1 : victim;

    assign fill_line = (ctrl.fill_src == fill_pbuf) ? pbuf_line_q : pmem_rdata;
    assign hit_line  = hit1 ? data_q[1][req.index] : data_q[0][req.index];

    // during a promote the arrays miss, so the word comes from the fill line
    assign src_line = array_hit ? hit_line : fill_line;
    assign word_sel = req.offset[offset_bits-1:2];
    assign mem_rdata = src_line[32*word_sel +: 32];

    // line-aligned request, demand or next line
    always_comb begin
        if (ctrl.use_next) begin
            pmem_address = word_t'({next_q.tag, next_q.index, offset_t'(0)});
        end else begin
            pmem_address = word_t'({req.tag, req.index, offset_t'(0)});
        end
    end

    // tag and line storage, no reset
    always_ff @(posedge clk) begin
        if (ctrl.load_way) begin
            tag_q[victim][req.index]  <= req.tag;
            data_q[victim][req.index] <= fill_line;
        end
    end

    // valid and LRU state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (ctrl.load_way) begin
                valid_q[victim][req.index] <= 1'b1;
            end
            // other way becomes the replacement candidate
            if (ctrl.load_lru) begin
                lru_q[req.index] <= ~used_way;
            end
        end
    end

    // buffer valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pbuf_valid_q <= 1'b0;
        end else if (ctrl.load_pbuf) begin
            pbuf_valid_q <= 1'b1;
        end else if (ctrl.clear_pbuf) begin
            pbuf_valid_q <= 1'b0;
        end
    end

    // buffer payload and saved next-line address
    always_ff @(posedge clk) begin
        if (ctrl.save_addr) begin
            next_q <= next_addr;
        end
        if (ctrl.load_pbuf) begin
            pbuf_line_q  <= pmem_rdata;
            pbuf_tag_q   <= next_q.tag;
            pbuf_index_q <= next_q.index;
        end
    end

endmodule

/* logic/icache_pkg.sv */
// instruction cache package
// geometry of the 2-way, 8-set, 32-byte-line cache,
// address split types and the control/datapath structs
package icache_pkg;

    // byte offset inside a line
    localparam int offset_bits = 5;
    // set index
    localparam int index_bits = 3;
    // everything above index and offset
    localparam int tag_bits = 32 - index_bits - offset_bits;
    localparam int num_sets = 2 ** index_bits;
    localparam int line_bits = 8 * (2 ** offset_bits);

    typedef logic [31:0] word_t;
    typedef logic [line_bits-1:0] line_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;

    // byte address split into its cache fields
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_t;

    // where a line written into the arrays comes from
    typedef enum logic {
        fill_mem  = 1'b0,
        fill_pbuf = 1'b1
    } fill_src_t;

    // commands from control to datapath
    typedef struct packed {
        logic      load_way;
        fill_src_t fill_src;
        logic      load_pbuf;
        logic      load_lru;
        logic      use_next;
        logic      clear_pbuf;
        logic      save_addr;
    } ctrl_t;

    // status from datapath to control
    typedef struct packed {
        logic array_hit;
        logic pbuf_hit;
        logic pbuf_valid;
        logic next_present;
    } stat_t;

endpackage

/* sim.f */
logic/icache_pkg.sv
logic/icache_datapath.sv
logic/icache_control.sv
logic/icache.sv
tests/line_memory_model.sv
tests/icache_chk.sv
tests/tb_icache.sv

/* tests/icache_chk.sv */
// protocol and data checks on the instruction cache ports
// bound into the cache top level
`timescale 1ns/1ps

module icache_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              mem_read,
    input icache_pkg::word_t mem_address,
    input logic              mem_resp,
    input icache_pkg::word_t mem_rdata,
    input logic              pmem_read,
    input icache_pkg::word_t pmem_address,
    input logic              pmem_resp
);
    import icache_pkg::*;

    // failed assertions, read by the testbench at the end
    int fail_count = 0;

    // response is a one-cycle pulse
    resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp)
        else begin
            fail_count++;
            $error("mem_resp held for more than one cycle");
        end

    // only while the cpu is asking
    resp_under_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |-> mem_read)
        else begin
            fail_count++;
            $error("mem_resp without mem_read");
        end

    // request and address steady until memory answers
    pmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address))
        else begin
            fail_count++;
            $error("pmem_read or pmem_address changed before pmem_resp");
        end

    pmem_align: assert property (@(posedge clk) disable iff (!rst_n)
        pmem_read |-> pmem_address[offset_bits-1:0] == '0)
        else begin
            fail_count++;
            $error("pmem_address not line aligned");
        end

    // returned word is its own word address xor the memory pattern
    data_rule: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |-> mem_rdata == ({mem_address[31:2], 2'b00} ^ 32'h13579bdf))
        else begin
            fail_count++;
            $error("MISMATCH time=%0t mem_rdata got %h expected %h", $time,
                $sampled(mem_rdata),
                {$sampled(mem_address[31:2]), 2'b00} ^ 32'h13579bdf);
        end

    // quiet outputs in reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !mem_resp && !pmem_read)
        else begin
            fail_count++;
            $error("mem_resp or pmem_read high during reset");
        end

endmodule

/* tests/line_memory_model.sv */
// behavioral line memory for the cache fill port
// answers each line read a few random cycles later, every word at
// byte address A holds A xor 32'h13579bdf
`timescale 1ns/1ps

module line_memory_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pmem_read,
    input  icache_pkg::word_t pmem_address,
    output icache_pkg::line_t pmem_rdata,
    output logic              pmem_resp
);
    import icache_pkg::*;

    logic        busy_q;
    int unsigned delay_q;

    // eight words of one line, each from its own byte address
    function automatic line_t line_data(input word_t base);
        line_t data;
        for (int i = 0; i < 8; i++) begin
            data[32*i +: 32] = (base + 32'(4 * i)) ^ 32'h13579bdf;
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            delay_q    <= 0;
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
        end else if (pmem_resp) begin
            // answer lasts one cycle
            pmem_resp <= 1'b0;
        end else if (busy_q) begin
            if (delay_q == 1) begin
                busy_q     <= 1'b0;
                pmem_resp  <= 1'b1;
                pmem_rdata <= line_data(pmem_address);
            end else begin
                delay_q <= delay_q - 1;
            end
        end else if (pmem_read) begin
            // new request, answer 2 to 6 cycles after it rose
            busy_q  <= 1'b1;
            delay_q <= 1 + ($urandom % 5);
        end
    end

endmodule

/* tests/tb_icache.sv */
// testbench for the instruction cache
// cpu reads against a reference of ways, LRU and prefetch buffer,
// with line fills counted on the memory port
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int    timeout_cycles = 200;
    localparam word_t addr_x = 32'h0000_1000;

    logic  clk;
    logic  rst_n;
    logic  mem_read;
    word_t mem_address;
    logic  mem_resp;
    word_t mem_rdata;
    logic  pmem_read;
    word_t pmem_address;
    line_t pmem_rdata;
    logic  pmem_resp;

    int   errors = 0;
    // fills seen on the bus and fills the reference expects
    int   fills = 0;
    int   exp_fills = 0;
    logic pmem_read_prev = 1'b0;
    // last miss launched a prefetch, next request may be held
    logic prefetch_busy = 1'b0;

    // reference state, whole line numbers per set and way
    logic [26:0] ref_line [num_sets][2];
    logic        ref_valid [num_sets][2];
    logic        ref_lru [num_sets];
    logic [26:0] ref_pbuf;
    logic        ref_pbuf_valid;

    icache DUT (.*);
    line_memory_model mem_model (.*);

    bind icache icache_chk chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_address  (mem_address),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_read    (pmem_read),
        .pmem_address (pmem_address),
        .pmem_resp    (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // rising pmem_read, sampled away from the clock edge
    always @(negedge clk) begin
        if (pmem_read && !pmem_read_prev) begin
            fills++;
        end
        pmem_read_prev = pmem_read;
    end

    task automatic report_mismatch(input string name, input int got, input int expected);
        errors++;
        $display("MISMATCH time=%0t %s got %0d expected %0d", $time, name, got, expected);
    endtask

    // closing line with both counts, then the verdict
    task automatic finish_run();
        $display("errors: testbench %0d, assertions %0d", errors, DUT.chk.fail_count);
        if (errors == 0 && DUT.chk.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // one access in the reference, kind is 0 hit, 1 promote, 2 miss
    task automatic ref_access(input logic [26:0] line, output int kind, output logic prefetch);
        logic [2:0]  idx;
        logic [26:0] nxt;
        int          way;
        idx = line[2:0];
        nxt = line + 27'd1;
        way = -1;
        prefetch = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_line[idx][w] == line) begin
                way = w;
            end
        end
        if (way >= 0) begin
            kind = 0;
        end else begin
            // line goes into the LRU way, from the buffer if it is there
            way = int'(ref_lru[idx]);
            ref_line[idx][way]  = line;
            ref_valid[idx][way] = 1'b1;
            if (ref_pbuf_valid && ref_pbuf == line) begin
                kind = 1;
                ref_pbuf_valid = 1'b0;
            end else begin
                kind = 2;
                exp_fills++;
                prefetch = !((ref_pbuf_valid && ref_pbuf == nxt) ||
                    (ref_valid[nxt[2:0]][0] && ref_line[nxt[2:0]][0] == nxt) ||
                    (ref_valid[nxt[2:0]][1] && ref_line[nxt[2:0]][1] == nxt));
                if (prefetch) begin
                    ref_pbuf = nxt;
                    ref_pbuf_valid = 1'b1;
                end
            end
        end
        // the other way is replaced next
        ref_lru[idx] = (way == 0);
    endtask

    // one cpu read held until mem_resp, latency and fill count checked
    task automatic cpu_read(input word_t addr, output int lat);
        int   kind;
        logic prefetch;
        logic held;
        held = prefetch_busy;
        ref_access(addr[31:5], kind, prefetch);
        @(posedge clk);
        #1;
        mem_read    = 1'b1;
        mem_address = addr;
        lat = 0;
        @(negedge clk);
        while (!mem_resp && lat < timeout_cycles) begin
            @(negedge clk);
            lat++;
        end
        if (!mem_resp) begin
            errors++;
            $display("no mem_resp within %0d cycles for address %h", timeout_cycles, addr);
            finish_run();
        end else begin
            if (kind == 0 && !held && lat != 1) begin
                report_mismatch("mem_resp latency on array hit", lat, 1);
            end
            if (kind == 1 && !held && lat != 2) begin
                report_mismatch("mem_resp latency on buffer hit", lat, 2);
            end
            if (fills != exp_fills) begin
                report_mismatch("pmem_read fill count", fills, exp_fills);
            end
            // its rise comes after this response
            if (prefetch) begin
                exp_fills++;
            end
            prefetch_busy = prefetch;
            @(posedge clk);
            #1;
            mem_read = 1'b0;
        end
    endtask

    initial begin
        int    lat;
        word_t addr;
        void'($urandom(32'heb34ca5c));
        rst_n       = 1'b0;
        mem_read    = 1'b0;
        mem_address = '0;
        ref_pbuf       = '0;
        ref_pbuf_valid = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            ref_lru[s]      = 1'b0;
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // cold miss, demand fill of X then prefetch of X+32
        cpu_read(addr_x + 32'h8, lat);
        // same line while the prefetch is still out
        cpu_read(addr_x + 32'h4, lat);
        if (lat < 2) begin
            report_mismatch("mem_resp latency behind prefetch", lat, 2);
        end
        cpu_read(addr_x, lat);
        // next line from the buffer, then from the arrays
        cpu_read(addr_x + 32'h2c, lat);
        cpu_read(addr_x + 32'h34, lat);
        // three lines in set 4, the LRU one is evicted and refilled
        cpu_read(32'h0000_2080, lat);
        cpu_read(32'h0000_2180, lat);
        cpu_read(32'h0000_2280, lat);
        cpu_read(32'h0000_2084, lat);
        cpu_read(32'h0000_2188, lat);
        // 32 lines of window, more than the cache holds
        repeat (300) begin
            addr = 32'h0000_4000 + (($urandom % 1024) & 32'hffff_fffc);
            cpu_read(addr, lat);
        end

        // last prefetch has to finish before the final count
        lat = 0;
        @(negedge clk);
        while (pmem_read && lat < timeout_cycles) begin
            @(negedge clk);
            lat++;
        end
        if (pmem_read) begin
            errors++;
            $display("pmem_read still high %0d cycles after the last read", timeout_cycles);
        end else if (fills != exp_fills) begin
            report_mismatch("pmem_read fill count", fills, exp_fills);
        end
        finish_run();
    end

endmodule
